//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_recordMaster
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

.PHONY: sim clean

//--- project.f
+incdir+src
src/recordData_pkg.sv
src/recordCtrl_pkg.sv
src/sampleCollector.sv
src/wordBuffer.sv
src/recordController.sv
src/recordMaster.sv
sim/tb_recordMaster.sv

//--- sim/record_trace.txt
# Columns: letter, hex value. C command opcode, B sample bits (count in 39:32, bits LSB first),
# S idle cycles, P expected playback word, L expected last flag, O expected owTrue after a scan
C 0
B 20a5c31e0f
S 3
B 2012345678
S 2
C 1
C 2
P a5c31e0f
L 0
P 12345678
L 1
C 0
B 20cafef00d
B 0a000003ff
S 2
C 1
C 2
P a5c31e0f
P 12345678
L 0
P cafef00d
L 1
C 3
O 0
C 0
B 2000000000
S 2
C 1
C 3
O 1
C 2
P a5c31e0f
P 12345678
P cafef00d
P 00000000
L 1
C 4
C 2
S 4
C 3
O 0
S 5

//--- sim/tb_recordMaster.sv
`timescale 1ns/100ps

module tb_recordMaster;

    import recordData_pkg::*;
    import recordCtrl_pkg::*;

    localparam int waitLimit  = 1000;  // Longer than a full buffer scan in cycles
    localparam int lineCycles = 300;   // Watchdog budget per trace entry

    logic      clk = 1'b0;
    logic      resetN;
    cmd_t      cmd;
    logic      cmdValid;
    logic      cmdReady;
    logic      samplePulse;
    logic      dIn;
    playBeat_t playBeat;
    logic      playValid;
    logic      playReady;
    logic      owTrue;
    logic      owReady;

    byte         letters[$];
    logic [39:0] values[$];
    word_t       beats[$];     // Transferred playback words in arrival order
    logic        lastFlags[$];
    logic        seenLast = 1'b0;
    logic [31:0] rngState;
    int          traceLen = 0;
    int          errorCount = 0;

    recordMaster dut (
        .clk, .resetN, .cmd, .cmdValid, .cmdReady, .samplePulse, .dIn,
        .playBeat, .playValid, .playReady, .owTrue, .owReady
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Random back-pressure on the playback channel
    initial begin
        rngState  = 32'hcbac;
        playReady = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rngState  = xorshift32(rngState);
            playReady = rngState[0] | rngState[7];  // Ready about three cycles in four
        end
    end

    // Valid and ready at the falling edge means a transfer at the next rising edge
    always @(negedge clk) begin
        if (playValid && playReady) begin
            beats.push_back(playBeat.data);
            lastFlags.push_back(playBeat.last);
        end
    end

    task automatic flagMismatch(input string msg);
        errorCount++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic describeFailure(input string msg);
        errorCount++;
        $display("At %0t ns: %s", $time, msg);
    endtask

    task automatic expectNoBeats();
        if (beats.size() != 0) begin
            describeFailure($sformatf("%0d playback beats arrived that the trace did not expect",
                                      beats.size()));
        end
        beats.delete();
        lastFlags.delete();
    endtask

    task automatic sendCmd(input cmdOp_e op);
        int   waited;
        logic accepted;
        waited = 0;
        expectNoBeats();
        cmd.op   = op;
        cmdValid = 1'b1;
        @(negedge clk);
        while (!cmdReady && waited < waitLimit) begin
            waited++;
            @(negedge clk);
        end
        accepted = cmdReady;
        @(posedge clk);
        #1;
        cmdValid = 1'b0;
        if (!accepted) begin
            describeFailure($sformatf("Command %s was never accepted, cmdReady stayed low",
                                      op.name()));
        end
        // Check and clear drop the old scan status at the accepting edge
        if (accepted && (op == opCheck || op == opClear)) begin
            if (owReady !== 1'b0 || owTrue !== 1'b0) begin
                flagMismatch($sformatf("after %s owReady/owTrue are %b/%b, expected 0/0",
                                       op.name(), owReady, owTrue));
            end
        end
    endtask

    task automatic sendBits(input logic [39:0] v);
        int n;
        int i;
        n = int'(v[39:32]);
        for (i = 0; i < n; i++) begin
            samplePulse = 1'b1;
            dIn         = v[i];
            @(posedge clk);
            #1;
        end
        samplePulse = 1'b0;
    endtask

    // dIn toggles while samplePulse is low and must be ignored
    task automatic idleCycles(input int n);
        repeat (n) begin
            dIn = ~dIn;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expectWord(input word_t exp);
        int    waited;
        word_t got;
        waited = 0;
        while (beats.size() == 0 && waited < waitLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (beats.size() == 0) begin
            seenLast = 1'bx;
            describeFailure($sformatf("Playback beat with word %h never arrived", exp));
        end else begin
            got      = beats.pop_front();
            seenLast = lastFlags.pop_front();
            if (got !== exp) begin
                flagMismatch($sformatf("playback word is %h, expected %h", got, exp));
            end
        end
    endtask

    task automatic expectOwTrue(input logic exp);
        int waited;
        waited = 0;
        while (owReady !== 1'b1 && waited < waitLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (owReady !== 1'b1) begin
            describeFailure("Zero scan never finished, owReady stayed low");
        end else if (owTrue !== exp) begin
            flagMismatch($sformatf("owTrue is %b, expected %b", owTrue, exp));
        end
    endtask

    task automatic loadTrace();
        int          fd;
        int          fields;
        string       line;
        byte         letter;
        logic [39:0] value;
        fd = $fopen("sim/record_trace.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%c %h", letter, value);
                if (line.getc(0) != "#" && fields == 2) begin
                    letters.push_back(letter);
                    values.push_back(value);
                end
            end
            $fclose(fd);
        end
        traceLen = letters.size();
    endtask

    task automatic runTrace();
        int i;
        for (i = 0; i < traceLen; i++) begin
            case (letters[i])
                "C": sendCmd(cmdOp_e'(values[i][2:0]));
                "B": sendBits(values[i]);
                "S": idleCycles(int'(values[i][15:0]));
                "P": expectWord(values[i][31:0]);
                "L": begin
                    if (seenLast !== values[i][0]) begin
                        flagMismatch($sformatf("last flag is %b, expected %b",
                                               seenLast, values[i][0]));
                    end
                end
                "O": expectOwTrue(values[i][0]);
                default: describeFailure($sformatf("Trace entry %0d has unknown letter %c",
                                                   i, letters[i]));
            endcase
        end
    endtask

    initial begin
        resetN      = 1'b0;
        cmd         = '0;
        cmdValid    = 1'b0;
        samplePulse = 1'b0;
        dIn         = 1'b0;
        loadTrace();
        if (traceLen == 0) begin
            describeFailure("Trace file sim/record_trace.txt is missing or holds no entries");
        end else begin
            repeat (10) @(posedge clk);
            #1;
            resetN = 1'b1;
            if (cmdReady !== 1'b1 || playValid !== 1'b0 ||
                owTrue !== 1'b0 || owReady !== 1'b0) begin
                flagMismatch($sformatf("after reset ready %b valid %b owTrue %b owReady %b",
                                       cmdReady, playValid, owTrue, owReady));
            end
            runTrace();
            expectNoBeats();
            if (cmdReady !== 1'b1 || playValid !== 1'b0) begin
                flagMismatch($sformatf("at the end cmdReady/playValid are %b/%b, expected 1/0",
                                       cmdReady, playValid));
            end
        end
        $display("Trace lines: %0d, errors: %0d", traceLen, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (traceLen > 0);
        repeat (traceLen * lineCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with the trace unfinished",
                 traceLen * lineCycles);
        $display("Trace lines: %0d, errors: %0d", traceLen, errorCount);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- src/recordController.sv
`timescale 1ns/100ps
`include "record_defines.svh"

module recordController (
    input  logic                      clk,
    input  logic                      resetN,
    input  recordCtrl_pkg::cmd_t      cmd,
    input  logic                      cmdValid,
    output logic                      cmdReady,
    input  logic                      wordDone,
    input  recordData_pkg::count_t    wordCount,
    input  recordData_pkg::word_t     readWord,
    output logic                      captureEn,
    output logic                      stopClear,
    output logic                      writeEn,
    output logic                      clearBuf,
    output recordData_pkg::addr_t     readAddr,
    output recordData_pkg::playBeat_t playBeat,
    output logic                      playValid,
    input  logic                      playReady,
    output logic                      owTrue,
    output logic                      owReady
);

    import recordData_pkg::*;
    import recordCtrl_pkg::*;

    ctrlState_e state;
    count_t     readIdx;
    logic       cmdFire;
    logic       lastWord;
    logic       readDone;

    assign cmdReady = (state == stIdle) || (state == stRecord);
    assign cmdFire  = cmdValid && cmdReady;

    assign lastWord = ((readIdx + 1'b1) == wordCount);
    assign readDone = (readIdx >= wordCount);       // No stored word left to read
    assign readAddr = readIdx[`RECORD_ADDR_BITS-1:0];

    // Per-state outputs
    assign captureEn = (state == stRecord);
    assign writeEn   = wordDone && captureEn;
    assign stopClear = cmdFire && (state == stRecord) && (cmd.op == opStop);
    assign clearBuf  = (state == stClear);
    assign playValid = (state == stPlayOut);

    // Address is held in stPlayOut, so the read data stays put under back-pressure
    always_comb begin
        playBeat.data = readWord;
        playBeat.last = lastWord;
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state   <= stIdle;
            readIdx <= '0;
            owTrue  <= 1'b0;
            owReady <= 1'b0;
        end else begin
            unique case (state)
                stIdle: begin
                    if (cmdFire) begin
                        readIdx <= '0;
                        unique case (cmd.op)
                            opRecord:   state <= stRecord;
                            opPlayback: state <= stPlayFetch;
                            opCheck: begin
                                owTrue  <= 1'b0;
                                owReady <= 1'b0;
                                state   <= stScanFetch;
                            end
                            opClear: begin
                                owTrue  <= 1'b0;
                                owReady <= 1'b0;
                                state   <= stClear;
                            end
                            default:    state <= stIdle;    // Stop while idle
                        endcase
                    end
                end
                stRecord: begin
                    if (cmdFire && cmd.op == opStop) begin
                        state <= stIdle;
                    end
                end
                stPlayFetch: begin
                    // Address goes out this cycle and data arrives next
                    state <= readDone ? stIdle : stPlayOut;
                end
                stPlayOut: begin
                    if (playReady) begin
                        readIdx <= readIdx + 1'b1;
                        state   <= lastWord ? stIdle : stPlayFetch;
                    end
                end
                stScanFetch: begin
                    if (readDone) begin
                        owReady <= 1'b1;    // Whole buffer scanned without a zero word
                        state   <= stIdle;
                    end else begin
                        state <= stScanTest;
                    end
                end
                stScanTest: begin
                    if (readWord == '0) begin
                        owTrue  <= 1'b1;    // Stop at the first marker
                        owReady <= 1'b1;
                        state   <= stIdle;
                    end else begin
                        readIdx <= readIdx + 1'b1;
                        state   <= stScanFetch;
                    end
                end
                stClear:  state <= stIdle;
                default:  state <= stIdle;
            endcase
        end
    end

endmodule

//--- src/recordCtrl_pkg.sv
`include "record_defines.svh"

package recordCtrl_pkg;

    typedef enum logic [2:0] {
        opRecord,
        opStop,
        opPlayback,
        opCheck,
        opClear
    } cmdOp_e;

    typedef struct packed {
        cmdOp_e op;
    } cmd_t;

    typedef enum logic [2:0] {
        stIdle, stRecord, stPlayFetch, stPlayOut, stScanFetch, stScanTest, stClear
    } ctrlState_e;

endpackage

//--- src/recordData_pkg.sv
`include "record_defines.svh"

package recordData_pkg;

    // One committed word with the first sample in bit 0
    typedef logic [`RECORD_WORD_BITS-1:0] word_t;

    typedef logic [`RECORD_ADDR_BITS-1:0] addr_t;

    // Stored word count from 0 up to RECORD_DEPTH
    typedef logic [`RECORD_ADDR_BITS:0] count_t;

    // Playback output beat
    typedef struct packed {
        word_t data;
        logic  last;    // Final stored word
    } playBeat_t;

endpackage

//--- src/recordMaster.sv
`timescale 1ns/100ps
`include "record_defines.svh"

module recordMaster (
    input  logic                      clk,
    input  logic                      resetN,
    input  recordCtrl_pkg::cmd_t      cmd,
    input  logic                      cmdValid,
    output logic                      cmdReady,
    input  logic                      samplePulse,
    input  logic                      dIn,
    output recordData_pkg::playBeat_t playBeat,
    output logic                      playValid,
    input  logic                      playReady,
    output logic                      owTrue,
    output logic                      owReady
);

    import recordData_pkg::*;

    word_t  word;
    word_t  readWord;
    count_t wordCount;
    addr_t  readAddr;
    logic   wordDone;
    logic   captureEn;
    logic   stopClear;
    logic   writeEn;
    logic   clearBuf;

    sampleCollector sampler (
        .clk, .resetN, .captureEn, .samplePulse, .dIn, .stopClear,
        .word, .wordDone
    );

    wordBuffer buffer (
        .clk, .resetN, .writeEn, .writeWord(word), .clearBuf, .readAddr,
        .readWord, .wordCount
    );

    recordController ctrl (
        .clk, .resetN, .cmd, .cmdValid, .cmdReady, .wordDone, .wordCount,
        .readWord, .captureEn, .stopClear, .writeEn, .clearBuf, .readAddr,
        .playBeat, .playValid, .playReady, .owTrue, .owReady
    );

endmodule

//--- src/record_defines.svh
`ifndef RECORD_DEFINES_SVH
`define RECORD_DEFINES_SVH

// Width of one recorded word in samples
`define RECORD_WORD_BITS 32

// Buffer entries
`define RECORD_DEPTH 256

// Buffer address bits (the word count uses one more)
`define RECORD_ADDR_BITS 8

`endif

//--- src/sampleCollector.sv
`timescale 1ns/100ps
`include "record_defines.svh"

module sampleCollector (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  captureEn,
    input  logic                  samplePulse,
    input  logic                  dIn,
    input  logic                  stopClear,
    output recordData_pkg::word_t word,
    output logic                  wordDone
);

    import recordData_pkg::*;

    localparam int cntBits = $clog2(`RECORD_WORD_BITS);

    word_t              shiftReg;
    logic [cntBits-1:0] bitCount;
    logic               take;
    logic               lastBit;

    assign take    = captureEn && samplePulse;  // Sample accepted this cycle
    assign lastBit = (bitCount == cntBits'(`RECORD_WORD_BITS - 1));
    assign word    = shiftReg;

    // New bit enters at the top, so the oldest sample ends up in bit 0
    always_ff @(posedge clk) begin
        if (take) begin
            shiftReg <= {dIn, shiftReg[`RECORD_WORD_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            bitCount <= '0;
            wordDone <= 1'b0;
        end else begin
            // One-cycle strobe on the counter wrap
            wordDone <= take && lastBit && !stopClear;
            if (stopClear) begin
                bitCount <= '0;         // Drop partial word
            end else if (take) begin
                bitCount <= bitCount + 1'b1;    // Wraps after the last bit
            end
        end
    end

endmodule

//--- src/wordBuffer.sv
`timescale 1ns/100ps
`include "record_defines.svh"

module wordBuffer (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   writeEn,
    input  recordData_pkg::word_t  writeWord,
    input  logic                   clearBuf,
    input  recordData_pkg::addr_t  readAddr,
    output recordData_pkg::word_t  readWord,
    output recordData_pkg::count_t wordCount
);

    import recordData_pkg::*;

    word_t mem [0:`RECORD_DEPTH-1];
    addr_t writePtr;
    logic  full;
    logic  doWrite;

    assign writePtr = wordCount[`RECORD_ADDR_BITS-1:0];    // Next free slot
    assign full     = (wordCount == count_t'(`RECORD_DEPTH));
    assign doWrite  = writeEn && !full;                     // Words past the end are dropped

    always_ff @(posedge clk) begin
        if (!resetN) begin
            wordCount <= '0;
        end else if (clearBuf) begin
            wordCount <= '0;        // Contents stay and only the count goes
        end else if (doWrite) begin
            wordCount <= wordCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= writeWord;
        end
    end

    // Registered read port with one cycle of latency
    always_ff @(posedge clk) begin
        readWord <= mem[readAddr];
    end

endmodule
